// File: common/adxl_config.svh
`ifndef ADXL_CONFIG_SVH
`define ADXL_CONFIG_SVH

// clk cycles per SCLK half-period
`define SCLK_DIV 2

// Settle times in clk cycles
// Scaled down from the datasheet values
`define SETTLE_POWER   200 // Stands in for 40 ms
`define SETTLE_FILTER  50  // Stands in for 5 ms
`define SETTLE_RESET   20  // Stands in for 0.5 ms
`define SETTLE_DEFAULT 4   // Covers CS deassert time

// Settle timer width
`define SETTLE_BITS 16

`endif

// File: common/adxlPkg.sv
package adxlPkg;

    // ADXL362 instruction codes
    localparam logic [7:0] INSTR_WRITE = 8'h0A;
    localparam logic [7:0] INSTR_READ  = 8'h0B;

    // Registers that need a longer settle after access
    localparam logic [7:0] REG_SOFT_RESET = 8'h1F;
    localparam logic [7:0] REG_FILTER_CTL = 8'h2C;
    localparam logic [7:0] REG_POWER_CTL  = 8'h2D;

    // One SPI command as sent on the wire
    typedef struct packed {
        logic [7:0] instr; // First byte out
        logic [7:0] addr;
        logic [7:0] data;  // Don't care for reads
    } cmdT;

    // Command FSM
    typedef enum logic [2:0] {
        IDLE     = 3'd0, // Waiting for host
        SHIFT    = 3'd1, // Feeding three bytes
        WAITDONE = 3'd2, // Last byte in flight
        SETTLE   = 3'd3  // Register settle time
    } cmdStateT;

endpackage

// File: common/spiByteIf.sv
`timescale 1ns/10ps

interface spiByteIf;
    logic [7:0] txByte;  // Byte to shift out
    logic       txValid;
    logic       txLast;  // Closes the CS frame
    logic       txReady; // High while no byte shifts
    logic [7:0] rxByte;  // Byte shifted in
    logic       rxValid; // One cycle per finished byte

    // Command side
    modport master (
        output txByte, txValid, txLast,
        input  txReady, rxByte, rxValid
    );

    // Serializer side
    modport shifter (
        input  txByte, txValid, txLast,
        output txReady, rxByte, rxValid
    );
endinterface

// File: spi/spiMaster.sv
`timescale 1ns/10ps
`include "adxl_config.svh"

module spiMaster (
    input  logic      clk,
    input  logic      reset,
    spiByteIf.shifter bus,
    input  logic      i_spiMiso,
    output logic      o_spiSclk,
    output logic      o_spiMosi,
    output logic      o_spiCsN
);
    localparam int DIV_BITS = $clog2(`SCLK_DIV + 1);
    localparam logic [DIV_BITS-1:0] DIV_LAST = DIV_BITS'(`SCLK_DIV - 1);

    logic                shifting; // Byte in flight
    logic                csTail;   // Holding CS low after the last byte
    logic                lastByte; // Current byte ends the frame
    logic [DIV_BITS-1:0] divCnt;   // Position inside a half-period
    logic [3:0]          halfCnt;  // 16 half-periods per byte
    logic [7:0]          shiftReg; // Tx out at the top, rx in at the bottom
    logic                misoBit;  // Held from rising to falling edge
    logic                accept;
    logic                sclkEdge;
    logic                byteDone;

    assign accept   = bus.txValid && bus.txReady;
    assign sclkEdge = shifting && (divCnt == '0); // First edge one cycle after load
    assign byteDone = shifting && (halfCnt == 4'd15) && (divCnt == DIV_LAST);

    assign bus.txReady = !shifting;
    assign bus.rxByte  = shiftReg; // Complete once the last fall has shifted
    assign o_spiMosi   = shiftReg[7]; // MSB first

    // Sequencing and chip select
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            shifting    <= 1'b0;
            csTail      <= 1'b0;
            lastByte    <= 1'b0;
            divCnt      <= '0;
            halfCnt     <= '0;
            o_spiCsN    <= 1'b1;
            bus.rxValid <= 1'b0;
        end else begin
            bus.rxValid <= byteDone; // Lands 16 half-periods after accept
            if (accept) begin
                shifting <= 1'b1;
                csTail   <= 1'b0; // Next byte of the frame
                lastByte <= bus.txLast;
                divCnt   <= '0;
                halfCnt  <= '0;
                o_spiCsN <= 1'b0; // Falls ahead of first SCLK rise
            end else if (shifting) begin
                if (divCnt == DIV_LAST) begin
                    divCnt  <= '0;
                    halfCnt <= halfCnt + 4'd1; // Wraps to 0 at byte end
                end else begin
                    divCnt <= divCnt + 1'b1;
                end
                if (byteDone) begin
                    shifting <= 1'b0;
                    csTail   <= lastByte; // Start CS hold only at frame end
                end
            end else if (csTail) begin
                // One more half-period before CS rises
                if (divCnt == DIV_LAST) begin
                    csTail   <= 1'b0;
                    o_spiCsN <= 1'b1;
                end else begin
                    divCnt <= divCnt + 1'b1;
                end
            end
        end
    end

    // Mode 0 clock and data
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_spiSclk <= 1'b0;
            misoBit   <= 1'b0;
            shiftReg  <= '0;
        end else if (accept) begin
            shiftReg <= bus.txByte; // MSB valid before first rise
        end else if (sclkEdge) begin
            o_spiSclk <= !halfCnt[0]; // Even half-period rises
            if (!halfCnt[0]) begin
                misoBit <= i_spiMiso; // Sample on rise
            end else begin
                shiftReg <= {shiftReg[6:0], misoBit}; // Shift on fall
            end
        end
    end
endmodule

// File: logic/cmdHandler.sv
`timescale 1ns/10ps
`include "adxl_config.svh"

module cmdHandler (
    input  logic         clk,
    input  logic         reset,
    input  logic         i_cmdValid,
    input  adxlPkg::cmdT i_cmd,
    output logic         o_cmdReady,
    output logic         o_rdValid,
    output logic [7:0]   o_rdData,
    output logic         o_busy,
    spiByteIf.master     bus,
    input  logic         i_csN
);
    import adxlPkg::*;

    localparam int SETTLE_W = `SETTLE_BITS;

    cmdStateT            state;
    cmdT                 cmdReg;     // Command held for the whole frame
    logic [1:0]          byteIdx;    // Which of the three bytes is offered
    logic [SETTLE_W-1:0] settleCnt;  // Cycles left in SETTLE
    logic [SETTLE_W-1:0] settleLoad; // Count for the latched register
    logic                accept;
    logic                byteSent;
    logic                isRead;
    logic                rdCapture;

    assign accept    = i_cmdValid && o_cmdReady;
    assign byteSent  = bus.txValid && bus.txReady;
    assign isRead    = (cmdReg.instr == INSTR_READ);
    // Only the third byte is still returning in WAITDONE
    assign rdCapture = bus.rxValid && (state == WAITDONE) && isRead;

    // Busy from the last byte until ready returns
    assign o_busy = (state == WAITDONE) || (state == SETTLE);

    // Byte offered to the shifter
    assign bus.txValid = (state == SHIFT);
    assign bus.txLast  = (byteIdx == 2'd2);

    always_comb begin
        case (byteIdx)
            2'd0:    bus.txByte = cmdReg.instr;
            2'd1:    bus.txByte = cmdReg.addr;
            default: bus.txByte = cmdReg.data;
        endcase
    end

    // Settle per register, minus one for the zero-based count
    always_comb begin
        case (cmdReg.addr)
            REG_POWER_CTL:  settleLoad = SETTLE_W'(`SETTLE_POWER - 1);
            REG_FILTER_CTL: settleLoad = SETTLE_W'(`SETTLE_FILTER - 1);
            REG_SOFT_RESET: settleLoad = SETTLE_W'(`SETTLE_RESET - 1);
            default:        settleLoad = SETTLE_W'(`SETTLE_DEFAULT - 1);
        endcase
    end

    // Host fields are taken on the handshake edge
    always_ff @(posedge clk) begin
        if (accept) begin
            cmdReg <= i_cmd;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= IDLE;
            byteIdx    <= '0;
            settleCnt  <= '0;
            o_cmdReady <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    o_cmdReady <= !accept; // Rises the cycle after reset
                    byteIdx    <= '0;
                    if (accept) begin
                        state <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (byteSent) begin
                        if (byteIdx == 2'd2) begin
                            state <= WAITDONE;
                        end else begin
                            byteIdx <= byteIdx + 2'd1; // Next byte straight away
                        end
                    end
                end
                WAITDONE: begin
                    // Frame over once the shifter lets CS go
                    if (i_csN) begin
                        state     <= SETTLE;
                        settleCnt <= settleLoad;
                    end
                end
                SETTLE: begin
                    if (settleCnt == '0) begin
                        state      <= IDLE;
                        o_cmdReady <= 1'b1; // Ready right after the last settle cycle
                    end else begin
                        settleCnt <= settleCnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Read result
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_rdValid <= 1'b0;
        end else begin
            o_rdValid <= rdCapture; // Single pulse per read
        end
    end

    always_ff @(posedge clk) begin
        if (rdCapture) begin
            o_rdData <= bus.rxByte;
        end
    end
endmodule

// File: logic/adxlCtrl.sv
`timescale 1ns/10ps

module adxlCtrl (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_cmdValid,
    input  logic [7:0] i_cmdInstr,
    input  logic [7:0] i_cmdAddr,
    input  logic [7:0] i_cmdData,
    output logic       o_cmdReady,
    output logic       o_busy,
    output logic       o_rdValid,
    output logic [7:0] o_rdData,
    input  logic       i_spiMiso,
    output logic       o_spiSclk,
    output logic       o_spiMosi,
    output logic       o_spiCsN
);
    import adxlPkg::*;

    cmdT cmdIn; // Host fields as one word

    spiByteIf byteBus ();

    assign cmdIn = '{instr: i_cmdInstr, addr: i_cmdAddr, data: i_cmdData};

    cmdHandler cmdHandlerInst (
        .clk        (clk),
        .reset      (reset),
        .i_cmdValid (i_cmdValid),
        .i_cmd      (cmdIn),
        .o_cmdReady (o_cmdReady),
        .o_rdValid  (o_rdValid),
        .o_rdData   (o_rdData),
        .o_busy     (o_busy),
        .bus        (byteBus.master),
        .i_csN      (o_spiCsN)     // Frame end seen by the FSM
    );

    spiMaster spiMasterInst (
        .clk       (clk),
        .reset     (reset),
        .bus       (byteBus.shifter),
        .i_spiMiso (i_spiMiso),
        .o_spiSclk (o_spiSclk),
        .o_spiMosi (o_spiMosi),
        .o_spiCsN  (o_spiCsN)
    );
endmodule

// File: bench/tbClock.sv
`timescale 1ns/10ps

module tbClock #(
    parameter int HALF_PERIOD = 20 // 40 ns clk
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Four rising edges in reset, released just after the fourth
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #2 reset = 1'b0;
    end
endmodule

// File: bench/adxlSlaveModel.sv
`timescale 1ns/10ps

module adxlSlaveModel (
    input  logic i_sclk,
    input  logic i_mosi,
    input  logic i_csN,
    output logic o_miso
);
    import adxlPkg::*;

    logic [7:0] regs [0:255]; // Register file of the sensor
    logic [7:0] shiftIn;
    logic [7:0] instr;
    logic [7:0] addr;
    logic [7:0] rdByte;       // Returned in the third byte
    int         bitCnt;       // SCLK rises seen in this frame

    initial begin
        for (int a = 0; a < 256; a++) begin
            regs[a] = 8'(a) ^ 8'hA5; // Value before any write
        end
        o_miso = 1'b0;
        bitCnt = 0;
    end

    // CS fall starts a frame, SCLK rise samples MOSI
    always @(posedge i_sclk or negedge i_csN) begin
        if (!i_sclk) begin
            bitCnt = 0;
        end else if (!i_csN) begin
            shiftIn = {shiftIn[6:0], i_mosi};
            bitCnt  = bitCnt + 1;
            if (bitCnt == 8) begin
                instr = shiftIn;
            end else if (bitCnt == 16) begin
                addr   = shiftIn;
                rdByte = regs[shiftIn];
            end else if (bitCnt == 24 && instr == INSTR_WRITE) begin
                regs[addr] = shiftIn; // Data byte lands
            end
        end
    end

    // Mode 0 slave, next bit put out on the fall
    always @(negedge i_sclk) begin
        if (!i_csN && bitCnt >= 16 && bitCnt < 24) begin
            o_miso <= rdByte[23 - bitCnt];
        end else begin
            o_miso <= 1'b0;
        end
    end
endmodule

// File: bench/adxlChecker.sv
`timescale 1ns/10ps
`include "adxl_config.svh"

module adxlChecker (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_cmdValid,
    input  logic       i_cmdReady,
    input  logic [7:0] i_cmdInstr,
    input  logic [7:0] i_cmdAddr,
    input  logic [7:0] i_cmdData,
    input  logic [7:0] i_expRdData,
    input  logic       i_busy,
    input  logic       i_rdValid,
    input  logic [7:0] i_rdData,
    input  logic       i_spiSclk,
    input  logic       i_spiMosi,
    input  logic       i_spiCsN,
    output int         o_passCount,
    output int         o_failCount,
    output int         o_doneCount // Commands fully checked
);
    import adxlPkg::*;

    logic testBad; // Set by any failed check of the current test

    task automatic reportFail(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        testBad = 1'b1;
    endtask

    task automatic closeTest(input string name);
        if (testBad) begin
            o_failCount++;
            $display("%s failed", name);
        end else begin
            o_passCount++;
            $display("%s passed", name);
        end
        testBad = 1'b0;
    endtask

    // Settle per addressed register
    function automatic int settleCycles(input logic [7:0] addr);
        case (addr)
            REG_POWER_CTL:  return `SETTLE_POWER;
            REG_FILTER_CTL: return `SETTLE_FILTER;
            REG_SOFT_RESET: return `SETTLE_RESET;
            default:        return `SETTLE_DEFAULT;
        endcase
    endfunction

    task automatic checkReset();
        int waitCycles;
        @(posedge clk);
        while (reset) begin
            @(posedge clk);
            if (i_spiCsN !== 1'b1 || i_cmdReady !== 1'b0 || i_spiSclk !== 1'b0 ||
                i_spiMosi !== 1'b0 || i_rdValid !== 1'b0) begin
                reportFail("SPI bus, ready or read valid not idle during reset");
            end
        end
        waitCycles = 0;
        while (i_cmdReady !== 1'b1 && waitCycles < 4) begin
            @(posedge clk);
            waitCycles++;
            if (i_spiSclk !== 1'b0 || i_spiCsN !== 1'b1) begin
                reportFail("SPI activity before the first ready");
            end
        end
        if (i_cmdReady !== 1'b1) begin
            reportFail("o_cmdReady did not rise after reset");
        end
        closeTest("reset behavior");
    endtask

    task automatic checkCommand();
        logic [7:0]  instr;
        logic [7:0]  addr;
        logic [7:0]  data;
        logic [7:0]  expRd;
        logic [7:0]  rdGot;
        logic [23:0] bits;   // MOSI as decoded
        logic        prevSclk;
        int          rises;
        int          rdPulses;
        int          cycles;
        string       name;
        // Current sample may already be the handshake
        while (!(i_cmdValid && i_cmdReady)) begin
            @(posedge clk);
            if (!i_spiCsN || i_spiSclk) begin
                reportFail("SPI frame started without an accepted command");
            end
        end
        instr = i_cmdInstr;
        addr  = i_cmdAddr;
        data  = i_cmdData;
        expRd = i_expRdData;
        name  = $sformatf("vector %0d %s addr %02h", o_doneCount + 1,
                          (instr == INSTR_READ) ? "READ" : "WRITE", addr);
        bits     = '0;
        prevSclk = 1'b0;
        rises    = 0;
        rdPulses = 0;
        rdGot    = '0;
        // CS-low window ends at the first sample with CS back high
        do begin
            @(posedge clk);
            if (i_spiSclk && !prevSclk && !i_spiCsN) begin
                bits = {bits[22:0], i_spiMosi}; // MSB first
                rises++;
            end
            prevSclk = i_spiSclk;
            if (i_rdValid) begin
                rdPulses++;
                rdGot = i_rdData;
            end
        end while (!(i_spiCsN && rises > 0));
        if (rises != 24) begin
            reportFail($sformatf("%s: %0d SCLK rises in one frame, expected 24", name, rises));
        end
        if (bits != {instr, addr, data}) begin
            reportFail($sformatf("%s: MOSI %06h, expected %06h", name, bits,
                                 {instr, addr, data}));
        end
        if (instr == INSTR_READ) begin
            if (rdPulses != 1) begin
                reportFail($sformatf("%s: %0d o_rdValid pulses, expected 1", name, rdPulses));
            end else if (rdGot != expRd) begin
                reportFail($sformatf("%s: o_rdData %02h, expected %02h", name, rdGot, expRd));
            end
        end else if (rdPulses != 0) begin
            reportFail($sformatf("%s: o_rdValid pulsed on a write", name));
        end
        // Settle counted from the CS rise
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (i_rdValid) begin
                reportFail($sformatf("%s: o_rdValid during settle", name));
            end
            if (!i_cmdReady && !i_busy) begin
                reportFail($sformatf("%s: o_busy low during settle", name));
            end
            if (!i_spiCsN) begin
                reportFail($sformatf("%s: CS low again during settle", name));
            end
        end while (!i_cmdReady);
        if (cycles != settleCycles(addr) + 1) begin
            reportFail($sformatf("%s: ready %0d cycles after CS rise, expected %0d", name,
                                 cycles, settleCycles(addr) + 1));
        end
        closeTest(name);
        o_doneCount++;
    endtask

    initial begin
        o_passCount = 0;
        o_failCount = 0;
        o_doneCount = 0;
        testBad     = 1'b0;
        checkReset();
        forever checkCommand();
    end
endmodule

// File: bench/adxlTb.sv
`timescale 1ns/10ps
`include "adxl_config.svh"

module adxlTb;
    localparam int MAX_VECTORS = 32;
    localparam int CYCLES_PER_VECTOR = 60 * `SCLK_DIV + `SETTLE_POWER + 20;
    localparam logic [31:0] NO_VECTOR = 32'hFFFF_FFFF; // Unfilled entry

    logic        clk;
    logic        reset;
    logic        cmdValid;
    logic [7:0]  cmdInstr;
    logic [7:0]  cmdAddr;
    logic [7:0]  cmdData;
    logic [7:0]  expRdData;
    logic        cmdReady;
    logic        busy;
    logic        rdValid;
    logic [7:0]  rdData;
    logic        spiMiso;
    logic        spiSclk;
    logic        spiMosi;
    logic        spiCsN;
    int          passCount;
    int          failCount;
    int          doneCount;
    int          numVectors;
    logic [31:0] vectors [0:MAX_VECTORS-1]; // instr, addr, data, expected read
    logic [31:0] lcgState;

    tbClock clockGen (.clk(clk), .reset(reset));

    adxlCtrl i_adxlCtrl (
        .clk        (clk),
        .reset      (reset),
        .i_cmdValid (cmdValid),
        .i_cmdInstr (cmdInstr),
        .i_cmdAddr  (cmdAddr),
        .i_cmdData  (cmdData),
        .o_cmdReady (cmdReady),
        .o_busy     (busy),
        .o_rdValid  (rdValid),
        .o_rdData   (rdData),
        .i_spiMiso  (spiMiso),
        .o_spiSclk  (spiSclk),
        .o_spiMosi  (spiMosi),
        .o_spiCsN   (spiCsN)
    );

    adxlSlaveModel slaveModel (.i_sclk(spiSclk), .i_mosi(spiMosi), .i_csN(spiCsN),
                               .o_miso(spiMiso));

    adxlChecker scoreboard (
        .clk         (clk),
        .reset       (reset),
        .i_cmdValid  (cmdValid),
        .i_cmdReady  (cmdReady),
        .i_cmdInstr  (cmdInstr),
        .i_cmdAddr   (cmdAddr),
        .i_cmdData   (cmdData),
        .i_expRdData (expRdData),
        .i_busy      (busy),
        .i_rdValid   (rdValid),
        .i_rdData    (rdData),
        .i_spiSclk   (spiSclk),
        .i_spiMosi   (spiMosi),
        .i_spiCsN    (spiCsN),
        .o_passCount (passCount),
        .o_failCount (failCount),
        .o_doneCount (doneCount)
    );

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Inputs change 2 ns after the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic sendCommand(input logic [31:0] vec, input int idle, input logic early);
        logic accepted;
        if (!early) begin
            while (!cmdReady) nextCycle();
        end
        repeat (idle) nextCycle(); // Early mode lands inside the busy window
        cmdValid = 1'b1;
        {cmdInstr, cmdAddr, cmdData, expRdData} = vec;
        accepted = 1'b0;
        while (!accepted) begin
            accepted = cmdReady; // Taken on the coming edge
            nextCycle();
        end
        cmdValid = 1'b0;
    endtask

    initial begin
        logic [31:0] rnd;
        cmdValid  = 1'b0;
        cmdInstr  = '0;
        cmdAddr   = '0;
        cmdData   = '0;
        expRdData = '0;
        lcgState  = 32'h4ac0;
        for (int i = 0; i < MAX_VECTORS; i++) begin
            vectors[i] = NO_VECTOR;
        end
        $readmemh("bench/adxl_vectors.txt", vectors);
        numVectors = 0;
        while (numVectors < MAX_VECTORS && vectors[numVectors] != NO_VECTOR) begin
            numVectors++;
        end
        if (numVectors == 0) begin
            $display("No command vectors could be read from bench/adxl_vectors.txt");
        end
        @(negedge reset);
        nextCycle();
        for (int v = 0; v < numVectors; v++) begin
            rnd = nextRandom();
            sendCommand(vectors[v], int'(rnd[18:16]), rnd[24]);
        end
        wait (doneCount == numVectors);
        $display("Summary: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0 && numVectors > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        @(negedge reset);
        repeat (numVectors * CYCLES_PER_VECTOR + 10) @(posedge clk);
        $display("Timeout: the commands did not all complete within %0d clk cycles",
                 numVectors * CYCLES_PER_VECTOR + 10);
        $display("TEST FAILED");
        $finish;
    end
endmodule

// File: bench/adxl_vectors.txt
// One command per line: instr_addr_data_expectedRead (hex)
// Expected read is the last byte written to addr, else addr ^ A5
0B_00_00_A5
0A_2C_13_00
0B_2C_00_13
0A_2D_02_00
0B_2D_FF_02
0A_20_5A_00
0B_21_00_84
0B_20_00_5A
0A_1F_52_00
0B_1F_00_52
0A_27_C3_00
0B_0B_00_AE
0B_27_3C_C3
0A_2C_91_00
0B_2C_00_91
0B_FF_00_5A

// File: compile.f
+incdir+common
common/adxlPkg.sv
common/spiByteIf.sv
spi/spiMaster.sv
logic/cmdHandler.sv
logic/adxlCtrl.sv
bench/tbClock.sv
bench/adxlSlaveModel.sv
bench/adxlChecker.sv
bench/adxlTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= adxlTb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
FILELIST  ?= compile.f

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard common/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
